/* common/riscvIsaPkg.sv */
// RV32I opcode subset used by decode only, with J and B immediates decoded and no compressed or custom encodings
package riscvIsaPkg;

    // Major opcodes seen by the decode stage
    typedef enum logic [6:0] {
        LOAD     = 7'b0000011,
        MISC_MEM = 7'b0001111, // FENCE, FENCE.I
        OP_IMM   = 7'b0010011,
        AUIPC    = 7'b0010111,
        STORE    = 7'b0100011,
        OP       = 7'b0110011,
        LUI      = 7'b0110111,
        BRANCH   = 7'b1100011,
        JALR     = 7'b1100111,
        JAL      = 7'b1101111,
        SYSTEM   = 7'b1110011
    } RvOpcode;

    // Full machine word, also the width of every displacement
    typedef logic [31:0] RvXlenWord;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        RvOpcode    opcode;
    } RvFormatJ;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        RvOpcode    opcode;
    } RvFormatB;

    // Same fetched word, read as J or B depending on the opcode
    typedef union packed {
        logic [31:0] raw;
        RvFormatJ    j;
        RvFormatB    b;
    } RvInsnWord;

    // Byte offset of a JAL, +-1 MiB
    function automatic RvXlenWord jalDisplacement(input RvFormatJ insn);
        return {{11{insn.imm20}}, insn.imm20, insn.imm19to12, insn.imm11,
                insn.imm10to1, 1'b0};
    endfunction

    // Byte offset of a conditional branch, +-4 KiB
    function automatic RvXlenWord branchDisplacement(input RvFormatB insn);
        return {{19{insn.imm12}}, insn.imm12, insn.imm11, insn.imm10to5,
                insn.imm4to1, 1'b0};
    endfunction

endpackage

/* common/frontendPkg.sv */
// Front-end bundle types for a two-lane fetch group and 32-bit PCs, compiled after the ISA package
package frontendPkg;

    localparam int DECODE_WIDTH = 2;  // Lanes per fetch group
    localparam int PC_WIDTH     = 32;
    localparam int INSN_BYTES   = 4;  // No compressed instructions

    typedef logic [PC_WIDTH-1:0]             PcPath;
    typedef logic [7:0]                      BrHistoryPath;
    typedef logic [$clog2(DECODE_WIDTH)-1:0] LaneIndex;

    // Return address stack state saved at prediction time
    typedef struct packed {
        logic [3:0] stackTopPtr;
        logic [3:0] queueTailPtr;
    } RasCheckpoint;

    typedef struct packed {
        logic         predTaken;
        PcPath        predAddr;
        BrHistoryPath globalHistory;
        RasCheckpoint rasCheckpoint;
    } BranchPred;

    typedef struct packed {
        logic                  valid;
        PcPath                 pc;
        riscvIsaPkg::RvInsnWord insn;
        BranchPred             pred;
    } FetchLane;

    typedef FetchLane [DECODE_WIDTH-1:0] FetchGroup;

    typedef enum logic [1:0] {
        NEXT        = 2'd0, // Falls through to pc + 4
        PC_RELATIVE = 2'd1, // BRANCH, JAL
        INDIRECT    = 2'd2, // JALR, target unknown here
        SERIALIZED  = 2'd3  // Younger lanes must be refetched
    } BranchClass;

    typedef struct packed {
        BranchClass brClass;
        logic       isJal;
        PcPath      displacement;
    } InsnInfo;

    typedef struct packed {
        logic                   valid;
        logic                   flushed;
        logic                   flushTriggering;
        PcPath                  pc;
        riscvIsaPkg::RvInsnWord insn;
        BranchPred              pred;
    } DecodedLane;

    // Recovery sent back to fetch
    typedef struct packed {
        logic         valid;
        PcPath        pc;
        BrHistoryPath history;
        RasCheckpoint ras;
    } DecodeRedirect;

endpackage

/* decode/insnClassifier.sv */
// Decodes opcodes only, so malformed encodings of a known opcode are classified by opcode alone
`timescale 1ns/10ps

module insnClassifier (
    input  frontendPkg::FetchGroup                            latchedGroup,
    output frontendPkg::InsnInfo [frontendPkg::DECODE_WIDTH-1:0] laneInfo
);
    import riscvIsaPkg::*;
    import frontendPkg::*;

    RvInsnWord laneWord   [DECODE_WIDTH];
    RvOpcode   laneOpcode [DECODE_WIDTH];

    // Opcode field sits in the same bits for every format
    always_comb begin
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            laneWord[i]   = latchedGroup[i].insn;
            laneOpcode[i] = laneWord[i].j.opcode;
        end
    end

    always_comb begin
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            laneInfo[i].brClass      = NEXT;
            laneInfo[i].isJal        = 1'b0;
            laneInfo[i].displacement = '0;

            case (laneOpcode[i])
                JAL: begin
                    laneInfo[i].brClass      = PC_RELATIVE;
                    laneInfo[i].isJal        = 1'b1;
                    laneInfo[i].displacement = jalDisplacement(laneWord[i].j); // J view
                end
                BRANCH: begin
                    laneInfo[i].brClass      = PC_RELATIVE;
                    laneInfo[i].displacement = branchDisplacement(laneWord[i].b); // B view
                end
                JALR: begin
                    laneInfo[i].brClass = INDIRECT; // Register target, resolved later
                end
                MISC_MEM, SYSTEM: begin
                    laneInfo[i].brClass = SERIALIZED;
                end
                default: begin
                    laneInfo[i].brClass = NEXT;
                end
            endcase
        end
    end

endmodule

/* decode/decodedBranchResolver.sv */
// Resolves only what decode can see, so JALR targets and branch directions are left to execute
`timescale 1ns/10ps

module decodedBranchResolver (
    input  frontendPkg::FetchGroup                                  latchedGroup,
    input  frontendPkg::InsnInfo    [frontendPkg::DECODE_WIDTH-1:0] laneInfo,
    output frontendPkg::DecodedLane [frontendPkg::DECODE_WIDTH-1:0] resolvedLanes,
    output frontendPkg::DecodeRedirect                              resolvedRedirect
);
    import frontendPkg::*;

    PcPath    decodedTarget [DECODE_WIDTH];
    LaneIndex checkLane;     // Lane where the walk stopped
    logic     addrCheck;     // Compare predAddr at checkLane
    logic     certainMiss;   // Redirect regardless of predAddr
    logic     walkDone;
    logic     flushTrig;

    // Target computed from the instruction bits
    always_comb begin
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            if (laneInfo[i].brClass == PC_RELATIVE) begin
                decodedTarget[i] = latchedGroup[i].pc + laneInfo[i].displacement;
            end else begin
                decodedTarget[i] = latchedGroup[i].pc + PcPath'(INSN_BYTES);
            end
        end
    end

    // Program-order walk up to the first lane that needs attention
    always_comb begin
        checkLane   = '0;
        addrCheck   = 1'b0;
        certainMiss = 1'b0;
        walkDone    = 1'b0;

        for (int i = 0; i < DECODE_WIDTH; i++) begin
            if (!walkDone) begin
                if (!latchedGroup[i].valid) begin
                    walkDone = 1'b1; // Valid lanes are contiguous
                end else if (laneInfo[i].brClass == SERIALIZED ||
                             (laneInfo[i].brClass == NEXT && latchedGroup[i].pred.predTaken)) begin
                    // Not a jump but fetch went elsewhere, or must refetch after it
                    checkLane   = LaneIndex'(i);
                    certainMiss = 1'b1;
                    walkDone    = 1'b1;
                end else if (laneInfo[i].brClass == PC_RELATIVE &&
                             (laneInfo[i].isJal || latchedGroup[i].pred.predTaken)) begin
                    checkLane = LaneIndex'(i);
                    addrCheck = 1'b1;
                    walkDone  = 1'b1;
                end else if (laneInfo[i].brClass == INDIRECT) begin
                    checkLane = LaneIndex'(i); // JALR stops without a check
                    walkDone  = 1'b1;
                end
            end
        end

        flushTrig = certainMiss ||
                    (addrCheck && latchedGroup[checkLane].pred.predAddr != decodedTarget[checkLane]);
    end

    always_comb begin
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            resolvedLanes[i].valid           = latchedGroup[i].valid;
            resolvedLanes[i].flushed         = 1'b0;
            resolvedLanes[i].flushTriggering = 1'b0;
            resolvedLanes[i].pc              = latchedGroup[i].pc;
            resolvedLanes[i].insn            = latchedGroup[i].insn;
            resolvedLanes[i].pred            = latchedGroup[i].pred;

            if (flushTrig) begin
                if (i == int'(checkLane)) begin
                    // Corrected prediction travels with the instruction
                    resolvedLanes[i].flushTriggering = 1'b1;
                    resolvedLanes[i].pred.predTaken  = 1'b1;
                    resolvedLanes[i].pred.predAddr   = decodedTarget[i];
                end else if (i > int'(checkLane)) begin
                    resolvedLanes[i].valid   = 1'b0; // Wrong path
                    resolvedLanes[i].flushed = 1'b1;
                end
            end
        end

        resolvedRedirect.valid   = flushTrig;
        resolvedRedirect.pc      = decodedTarget[checkLane];
        resolvedRedirect.history = latchedGroup[checkLane].pred.globalHistory;
        resolvedRedirect.ras     = latchedGroup[checkLane].pred.rasCheckpoint;
    end

endmodule

/* rtl/decodePipeRegs.sv */
// Both stages freeze together under stall, and only valid flags are reset so payload is X after reset
`timescale 1ns/10ps

module decodePipeRegs (
    input  logic                                                    clk,
    input  logic                                                    arstN,
    input  logic                                                    stall,
    input  frontendPkg::FetchGroup                                  fetchGroup,
    input  logic                                                    squash,
    input  frontendPkg::DecodedLane [frontendPkg::DECODE_WIDTH-1:0] resolvedLanes,
    input  frontendPkg::DecodeRedirect                              resolvedRedirect,
    output frontendPkg::FetchGroup                                  latchedGroup,
    output frontendPkg::DecodedLane [frontendPkg::DECODE_WIDTH-1:0] decodedGroup,
    output logic                                                    decodedValid,
    output frontendPkg::DecodeRedirect                              redirect
);
    import frontendPkg::*;

    FetchGroup                        latchPayload;
    logic       [DECODE_WIDTH-1:0]    latchValid;
    DecodedLane [DECODE_WIDTH-1:0]    outPayload;
    logic       [DECODE_WIDTH-1:0]    outValid;
    DecodeRedirect                    redirectPayload;
    logic                             redirectValid;

    // Valid flags of both stages and the redirect pulse
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            latchValid    <= '0;
            outValid      <= '0;
            redirectValid <= 1'b0;
        end else if (!stall) begin
            for (int i = 0; i < DECODE_WIDTH; i++) begin
                latchValid[i] <= fetchGroup[i].valid && !squash; // Wrong-path group dropped
                outValid[i]   <= resolvedLanes[i].valid;
            end
            redirectValid <= resolvedRedirect.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            latchPayload    <= fetchGroup;
            outPayload      <= resolvedLanes;
            redirectPayload <= resolvedRedirect;
        end
    end

    // Merge the reset valid bits back into the bundles
    always_comb begin
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            latchedGroup[i]       = latchPayload[i];
            latchedGroup[i].valid = latchValid[i];
            decodedGroup[i]       = outPayload[i];
            decodedGroup[i].valid = outValid[i];
        end
        redirect       = redirectPayload;
        redirect.valid = redirectValid;
        decodedValid   = |outValid;
    end

endmodule

/* rtl/frontendDecodeTop.sv */
// Decode stage with two cycles of latency, and fetch must hold its group while fetchStall is high
`timescale 1ns/10ps

module frontendDecodeTop (
    input  logic                                                    clk,
    input  logic                                                    arstN,
    input  frontendPkg::FetchGroup                                  fetchGroup,
    input  logic                                                    stall,
    output frontendPkg::DecodedLane [frontendPkg::DECODE_WIDTH-1:0] decodedGroup,
    output logic                                                    decodedValid,
    output frontendPkg::DecodeRedirect                              redirect,
    output logic                                                    fetchStall
);
    import frontendPkg::*;

    FetchGroup                     latchedGroup;
    InsnInfo    [DECODE_WIDTH-1:0] laneInfo;
    DecodedLane [DECODE_WIDTH-1:0] resolvedLanes;
    DecodeRedirect                 resolvedRedirect;

    assign fetchStall = stall; // Rename backpressure goes straight to fetch

    decodePipeRegs u_pipeRegs (
        .clk              (clk),
        .arstN            (arstN),
        .stall            (stall),
        .fetchGroup       (fetchGroup),
        .squash           (resolvedRedirect.valid), // Next fetch group is wrong-path
        .resolvedLanes    (resolvedLanes),
        .resolvedRedirect (resolvedRedirect),
        .latchedGroup     (latchedGroup),
        .decodedGroup     (decodedGroup),
        .decodedValid     (decodedValid),
        .redirect         (redirect)
    );

    insnClassifier u_classifier (
        .latchedGroup (latchedGroup),
        .laneInfo     (laneInfo)
    );

    decodedBranchResolver u_resolver (
        .latchedGroup     (latchedGroup),
        .laneInfo         (laneInfo),
        .resolvedLanes    (resolvedLanes),
        .resolvedRedirect (resolvedRedirect)
    );

endmodule

/* bench/decodeTb.sv */
// Random two-lane fetch groups with stall, checked against a reference model, and no JALR target checks
`timescale 1ns/10ps

module decodeTb;
    import riscvIsaPkg::*;
    import frontendPkg::*;

    localparam int          CLK_PERIOD      = 100;
    localparam int          NUM_GROUPS      = 2000;
    localparam int          WATCHDOG_CYCLES = NUM_GROUPS * 20 + 100;
    localparam logic [31:0] LFSR_SEED       = 32'hab22_d74b;

    typedef struct packed {
        DecodedLane [DECODE_WIDTH-1:0] lanes;
        DecodeRedirect                 redir;
    } ExpectedOut;

    logic                          clk = 1'b0;
    logic                          arstN;
    logic                          stall;
    FetchGroup                     fetchGroup;
    DecodedLane [DECODE_WIDTH-1:0] decodedGroup;
    logic                          decodedValid;
    DecodeRedirect                 redirect;
    logic                          fetchStall;

    logic [31:0] lfsrState;
    ExpectedOut  expQ [$];
    logic        squashNext;   // Previous accepted group redirected
    int          checked;
    int          redirectsSeen;
    int          cleanSeen;

    frontendDecodeTop u_dut (
        .clk          (clk),
        .arstN        (arstN),
        .fetchGroup   (fetchGroup),
        .stall        (stall),
        .decodedGroup (decodedGroup),
        .decodedValid (decodedValid),
        .redirect     (redirect),
        .fetchStall   (fetchStall)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hD000_0001) : (lfsrState >> 1);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // J-type immediate from the raw word
    function automatic PcPath jTypeOffset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    // B-type immediate from the raw word
    function automatic PcPath bTypeOffset(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic RvOpcode pickOpcode(input logic [3:0] sel);
        case (sel)
            4'd0:          return JAL;
            4'd1, 4'd2:    return BRANCH;
            4'd3:          return JALR;
            4'd4:          return MISC_MEM;
            4'd5:          return SYSTEM;
            4'd6, 4'd7:    return OP_IMM;
            4'd8, 4'd9:    return OP;
            4'd10:         return LUI;
            4'd11:         return AUIPC;
            4'd12:         return LOAD;
            4'd13:         return STORE;
            default:       return OP_IMM;
        endcase
    endfunction

    function automatic FetchGroup makeGroup();
        FetchGroup   g;
        logic        twoLanes;
        PcPath       basePc;
        RvOpcode     opc;
        PcPath       target;
        logic [31:0] bits;
        twoLanes = takeBits(1);
        basePc   = PcPath'(takeBits(30) << 2);
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            g[i].valid    = (i == 0) || twoLanes;
            g[i].pc       = basePc + PcPath'(INSN_BYTES * i);
            opc           = pickOpcode(takeBits(4));
            bits          = takeBits(25);
            g[i].insn.raw = {bits[24:0], opc};
            if (opc == JAL || opc == BRANCH) begin
                g[i].pred.predTaken = takeBits(1);
                target = g[i].pc + ((opc == JAL) ? jTypeOffset(g[i].insn.raw)
                                                 : bTypeOffset(g[i].insn.raw));
            end else begin
                g[i].pred.predTaken = (takeBits(3) == 0); // Rare bogus taken
                target = g[i].pc + 32'd4;
            end
            g[i].pred.predAddr      = takeBits(1) ? target : target + 32'd4; // Right or off by 4
            g[i].pred.globalHistory = takeBits(8);
            g[i].pred.rasCheckpoint = takeBits(8);
        end
        return g;
    endfunction

    // Expected decode result, written from the classification and resolution rules
    function automatic ExpectedOut resolveGroup(input FetchGroup g);
        ExpectedOut e;
        PcPath      target;
        PcPath      hitTarget;
        logic       stop;
        logic       miss;
        int         hit;
        logic [6:0] opc;
        hit       = -1;
        stop      = 1'b0;
        hitTarget = '0;
        e.redir   = '0;
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            e.lanes[i].valid           = g[i].valid;
            e.lanes[i].flushed         = 1'b0;
            e.lanes[i].flushTriggering = 1'b0;
            e.lanes[i].pc              = g[i].pc;
            e.lanes[i].insn            = g[i].insn;
            e.lanes[i].pred            = g[i].pred;
            if (!stop && !g[i].valid) begin
                stop = 1'b1;
            end else if (!stop) begin
                opc    = g[i].insn.raw[6:0];
                target = g[i].pc + 32'd4;
                miss   = 1'b0;
                case (opc)
                    JAL: begin
                        target = g[i].pc + jTypeOffset(g[i].insn.raw);
                        miss   = (g[i].pred.predAddr != target);
                        stop   = 1'b1;
                    end
                    BRANCH: begin
                        target = g[i].pc + bTypeOffset(g[i].insn.raw);
                        if (g[i].pred.predTaken) begin
                            miss = (g[i].pred.predAddr != target);
                            stop = 1'b1;
                        end
                    end
                    JALR: stop = 1'b1;
                    MISC_MEM, SYSTEM: begin
                        miss = 1'b1;
                        stop = 1'b1;
                    end
                    default: begin
                        miss = g[i].pred.predTaken;
                        stop = g[i].pred.predTaken;
                    end
                endcase
                if (miss) begin
                    hit       = i;
                    hitTarget = target;
                end
            end
        end
        if (hit >= 0) begin
            e.lanes[hit].flushTriggering = 1'b1;
            e.lanes[hit].pred.predTaken  = 1'b1;
            e.lanes[hit].pred.predAddr   = hitTarget;
            for (int j = hit + 1; j < DECODE_WIDTH; j++) begin
                e.lanes[j].valid   = 1'b0;
                e.lanes[j].flushed = 1'b1;
            end
            e.redir.valid   = 1'b1;
            e.redir.pc      = hitTarget;
            e.redir.history = g[hit].pred.globalHistory;
            e.redir.ras     = g[hit].pred.rasCheckpoint;
        end
        return e;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Wrong-path group right after a redirect yields no output
    task automatic acceptGroup(input FetchGroup g);
        ExpectedOut e;
        if (squashNext) begin
            squashNext = 1'b0;
        end else begin
            e = resolveGroup(g);
            expQ.push_back(e);
            squashNext = e.redir.valid;
        end
    endtask

    // Output register against one expected entry
    task automatic checkOutputs(input ExpectedOut e);
        logic anyValid;
        anyValid = 1'b0;
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            anyValid = anyValid | e.lanes[i].valid;
            checkValue($sformatf("decodedGroup[%0d].valid", i),
                       decodedGroup[i].valid, e.lanes[i].valid);
            checkValue($sformatf("decodedGroup[%0d].flushed", i),
                       decodedGroup[i].flushed, e.lanes[i].flushed);
            checkValue($sformatf("decodedGroup[%0d].flushTriggering", i),
                       decodedGroup[i].flushTriggering, e.lanes[i].flushTriggering);
            if (e.lanes[i].valid) begin
                checkValue($sformatf("decodedGroup[%0d].pc", i),
                           decodedGroup[i].pc, e.lanes[i].pc);
                checkValue($sformatf("decodedGroup[%0d].insn", i),
                           decodedGroup[i].insn, e.lanes[i].insn);
                checkValue($sformatf("decodedGroup[%0d].pred", i),
                           decodedGroup[i].pred, e.lanes[i].pred);
            end
        end
        checkValue("decodedValid", decodedValid, anyValid);
        checkValue("redirect.valid", redirect.valid, e.redir.valid);
        if (e.redir.valid) begin
            checkValue("redirect.pc", redirect.pc, e.redir.pc);
            checkValue("redirect.history", redirect.history, e.redir.history);
            checkValue("redirect.ras", redirect.ras, e.redir.ras);
        end
    endtask

    task automatic compareOutput(output ExpectedOut e);
        if (expQ.size() == 0) begin
            $display("ERROR: decode produced an output while no accepted group was pending");
            $display("TEST RESULT: FAIL");
            $fatal(1, "Unexpected output");
        end else begin
            e = expQ.pop_front();
            checkOutputs(e);
            if (e.redir.valid) begin
                redirectsSeen++;
            end else begin
                cleanSeen++;
            end
            checked++;
        end
    endtask

    // Output register only loads on edges without stall and holds otherwise
    initial begin
        logic       advanced;
        logic       holding;   // Output register carries a checked group
        ExpectedOut heldExp;
        holding = 1'b0;
        heldExp = '0;
        forever begin
            @(posedge clk);
            advanced = !stall;
            @(negedge clk);
            checkValue("fetchStall", fetchStall, stall);
            if (advanced) begin
                holding = decodedValid || redirect.valid;
                if (holding) begin
                    compareOutput(heldExp);
                end
            end else if (holding) begin
                checkOutputs(heldExp); // Frozen under stall
            end else begin
                checkValue("decodedValid", decodedValid, 1'b0);
                checkValue("redirect.valid", redirect.valid, 1'b0);
            end
        end
    end

    initial begin
        FetchGroup pending;
        int        issued;
        logic      nextStall;
        lfsrState     = LFSR_SEED;
        arstN         = 1'b0;
        stall         = 1'b0;
        fetchGroup    = '0;
        squashNext    = 1'b0;
        checked       = 0;
        redirectsSeen = 0;
        cleanSeen     = 0;
        issued        = 0;
        repeat (3) @(posedge clk);
        pending = makeGroup();
        arstN      <= 1'b1;
        fetchGroup <= pending;
        while (issued < NUM_GROUPS) begin
            @(posedge clk);
            if (!stall) begin
                acceptGroup(pending);
                issued++;
                pending = (issued < NUM_GROUPS) ? makeGroup() : FetchGroup'('0);
                fetchGroup <= pending;
            end
            nextStall = (takeBits(3) == 0); // About one cycle in eight
            if (issued == NUM_GROUPS) begin
                nextStall = 1'b0;
            end
            stall <= nextStall;
        end
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (redirectsSeen > 0 && cleanSeen > 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("ERROR: run ended with %0d groups checked, %0d redirects, %0d clean",
                     checked, redirectsSeen, cleanSeen);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Incomplete run");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, decoded outputs stopped arriving",
                 WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog timeout");
    end

endmodule

/* project.f */
common/riscvIsaPkg.sv
common/frontendPkg.sv
decode/insnClassifier.sv
decode/decodedBranchResolver.sv
rtl/decodePipeRegs.sv
rtl/frontendDecodeTop.sv
bench/decodeTb.sv

/* Bender.yml */
package:
  name: frontend_decode

sources:
  - common/riscvIsaPkg.sv
  - common/frontendPkg.sv
  - decode/insnClassifier.sv
  - decode/decodedBranchResolver.sv
  - rtl/decodePipeRegs.sv
  - rtl/frontendDecodeTop.sv
  - target: test
    files:
      - bench/decodeTb.sv
